/* include/wd_params.svh */
// word-guess search engine
// shared counts and widths
`ifndef WD_PARAMS_SVH
`define WD_PARAMS_SVH

// keyboard letters and guess length
`define WD_KEYS      8
`define WD_SLOTS     5

// datapath widths
`define WD_LETTER_W  5
`define WD_WEIGHT_W  4
`define WD_VALUE_W   11
`define WD_COUNT_W   3

`endif

/* hw/wd_pkg.sv */
// word-guess search engine
// common types for letters, weights, values, counts and the controller FSM
`include "wd_params.svh"

package wd_pkg;

    typedef logic [`WD_LETTER_W-1:0] letter_t;
    typedef logic [`WD_WEIGHT_W-1:0] weight_t;
    typedef logic [`WD_VALUE_W-1:0]  value_t;
    typedef logic [`WD_COUNT_W-1:0]  count_t;

    // wide enough to index all keys
    typedef logic [2:0] key_idx_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        COMBO,
        PERM,
        DRAIN,
        EMIT
    } wd_state_e;

endpackage

/* hw/wd_input_buffer.sv */
// input capture
// stores keys, answer letters, slot weights and the A/B target from 8 beats
`include "wd_params.svh"

module wd_input_buffer import wd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load_en,
    input  key_idx_t beat,
    input  letter_t  keyboard,
    input  letter_t  answer,
    input  weight_t  weight,
    input  count_t   match_target,
    output letter_t  keys    [`WD_KEYS],
    output letter_t  answers [`WD_SLOTS],
    output weight_t  weights [`WD_SLOTS],
    output count_t   target_a,
    output count_t   target_b
);

    // beat k lands on the edge that closes it
    always_ff @(posedge clk) begin
        if (load_en) begin
            keys[beat] <= keyboard;
            if (beat < `WD_SLOTS) begin
                answers[beat] <= answer;
                weights[beat] <= weight;
            end
            // A on beat 0, B on beat 1
            if (beat == key_idx_t'(0)) begin
                target_a <= match_target;
            end
            if (beat == key_idx_t'(1)) begin
                target_b <= match_target;
            end
        end
    end

    // one load burst covers all eight beats without a gap
    a_load_burst: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(load_en) |-> load_en [*`WD_KEYS] ##1 !load_en
    );

endmodule

/* hw/wd_combo_gen.sv */
// combination generator
// walks the 5-of-8 key index sets in order and flags the sets passing the pair prefilter
`include "wd_params.svh"

module wd_combo_gen import wd_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    combo_start,
    input  logic    combo_step,
    input  letter_t keys    [`WD_KEYS],
    input  letter_t answers [`WD_SLOTS],
    input  count_t  target_a,
    input  count_t  target_b,
    output letter_t chosen  [`WD_SLOTS],
    output logic    combo_hit,
    output logic    combo_done
);

    key_idx_t   idx     [`WD_SLOTS];
    key_idx_t   idx_nxt [`WD_SLOTS];
    logic [4:0] pair_cnt;
    int         piv;

    // ========================================================================
    // next index set
    // ========================================================================
    always_comb begin
        idx_nxt = idx;
        piv = `WD_SLOTS;
        // rightmost slot that can still move up
        for (int i = 0; i < `WD_SLOTS; i++) begin
            if (idx[i] != key_idx_t'(`WD_KEYS - `WD_SLOTS + i)) begin
                piv = i;
            end
        end
        for (int j = 0; j < `WD_SLOTS; j++) begin
            if (j >= piv) begin
                idx_nxt[j] = key_idx_t'(int'(idx[piv]) + 1 + j - piv);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `WD_SLOTS; i++) begin
                idx[i] <= key_idx_t'(i);
            end
        end else if (combo_start) begin
            for (int i = 0; i < `WD_SLOTS; i++) begin
                idx[i] <= key_idx_t'(i);
            end
        end else if (combo_step) begin
            idx <= idx_nxt;
        end
    end

    // ========================================================================
    // prefilter
    // ========================================================================
    // total letter pairs against the answer equals A+B for every order
    always_comb begin
        pair_cnt = '0;
        for (int i = 0; i < `WD_SLOTS; i++) begin
            chosen[i] = keys[idx[i]];
            for (int j = 0; j < `WD_SLOTS; j++) begin
                pair_cnt = pair_cnt + 5'(chosen[i] == answers[j]);
            end
        end
    end

    assign combo_hit  = (pair_cnt == 5'(target_a) + 5'(target_b));
    // last set is 3..7, the only one starting at 3
    assign combo_done = (idx[0] == key_idx_t'(`WD_KEYS - `WD_SLOTS));

    a_idx_ascending: assert property (
        @(posedge clk) disable iff (!rst_n)
        idx[0] < idx[1] && idx[1] < idx[2] && idx[2] < idx[3] && idx[3] < idx[4]
    );

endmodule

/* hw/wd_perm_gen.sv */
// permutation generator
// presents the 120 slot orders of the latched key set, one guess per cycle
`include "wd_params.svh"

module wd_perm_gen import wd_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    perm_start,
    input  logic    perm_step,
    input  letter_t chosen [`WD_SLOTS],
    output letter_t guess  [`WD_SLOTS],
    output logic    guess_valid,
    output logic    perm_done
);

    localparam int PERMS = 120;

    letter_t    set_r   [`WD_SLOTS];
    key_idx_t   ord     [`WD_SLOTS];
    key_idx_t   ord_nxt [`WD_SLOTS];
    key_idx_t   swp     [`WD_SLOTS];
    logic [6:0] perm_cnt;
    logic       active;
    int         piv;
    int         sw;

    // next lexicographic order: swap at the pivot, then reverse the tail
    always_comb begin
        piv = 0;
        sw  = 0;
        for (int i = 0; i < `WD_SLOTS - 1; i++) begin
            if (ord[i] < ord[i+1]) begin
                piv = i;
            end
        end
        for (int j = 0; j < `WD_SLOTS; j++) begin
            if (j > piv && ord[j] > ord[piv]) begin
                sw = j;
            end
        end
        swp      = ord;
        swp[piv] = ord[sw];
        swp[sw]  = ord[piv];
        for (int k = 0; k < `WD_SLOTS; k++) begin
            ord_nxt[k] = (k > piv) ? swp[`WD_SLOTS + piv - k] : swp[k];
        end
    end

    always_ff @(posedge clk) begin
        if (perm_start) begin
            set_r <= chosen;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            perm_cnt <= '0;
            for (int i = 0; i < `WD_SLOTS; i++) begin
                ord[i] <= key_idx_t'(i);
            end
        end else if (perm_start) begin
            active   <= 1'b1;
            perm_cnt <= '0;
            for (int i = 0; i < `WD_SLOTS; i++) begin
                ord[i] <= key_idx_t'(i);
            end
        end else if (perm_step && active) begin
            ord      <= ord_nxt;
            perm_cnt <= perm_cnt + 7'd1;
            if (perm_done) begin
                active <= 1'b0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `WD_SLOTS; i++) begin
            guess[i] = set_r[ord[i]];
        end
    end

    assign guess_valid = active;
    assign perm_done   = active && (perm_cnt == 7'(PERMS - 1));

endmodule

/* hw/wd_scorer.sv */
// guess scorer
// registers the A/B match flag and the weighted value of each presented guess
`include "wd_params.svh"

module wd_scorer import wd_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  letter_t guess   [`WD_SLOTS],
    input  logic    guess_valid,
    input  letter_t answers [`WD_SLOTS],
    input  weight_t weights [`WD_SLOTS],
    input  count_t  target_a,
    input  count_t  target_b,
    output logic    score_valid,
    output logic    score_match,
    output value_t  score_value,
    output letter_t score_guess [`WD_SLOTS]
);

    logic [4:0] a_cnt;
    logic [4:0] b_cnt;
    value_t     value;

    always_comb begin
        a_cnt = '0;
        b_cnt = '0;
        value = '0;
        for (int i = 0; i < `WD_SLOTS; i++) begin
            a_cnt = a_cnt + 5'(guess[i] == answers[i]);
            value = value + value_t'(guess[i]) * value_t'(weights[i]);
            // letter in the wrong slot
            for (int j = 0; j < `WD_SLOTS; j++) begin
                if (i != j) begin
                    b_cnt = b_cnt + 5'(guess[j] == answers[i]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score_valid <= 1'b0;
        end else begin
            score_valid <= guess_valid;
        end
    end

    always_ff @(posedge clk) begin
        score_match <= (a_cnt == 5'(target_a)) && (b_cnt == 5'(target_b));
        score_value <= value;
        score_guess <= guess;
    end

    a_ab_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        guess_valid |-> (a_cnt + b_cnt) <= 5
    );

endmodule

/* hw/wd_best_keeper.sv */
// best-guess record
// keeps the highest-valued matching guess, lexicographically smaller on a tie
`include "wd_params.svh"

module wd_best_keeper import wd_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    clear,
    input  logic    score_valid,
    input  logic    score_match,
    input  value_t  score_value,
    input  letter_t score_guess [`WD_SLOTS],
    output value_t  best_value,
    output letter_t best_guess  [`WD_SLOTS]
);

    logic have;
    logic lex_less;
    logic decided;
    logic take;

    // first differing slot decides, slot 0 first
    always_comb begin
        lex_less = 1'b0;
        decided  = 1'b0;
        for (int i = 0; i < `WD_SLOTS; i++) begin
            if (!decided && score_guess[i] != best_guess[i]) begin
                lex_less = (score_guess[i] < best_guess[i]);
                decided  = 1'b1;
            end
        end
    end

    assign take = score_valid && score_match &&
                  (!have || score_value > best_value ||
                   (score_value == best_value && lex_less));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have <= 1'b0;
        end else if (clear) begin
            have <= 1'b0;
        end else if (take) begin
            have <= 1'b1;
        end
    end

    // an empty record reads as zero
    always_ff @(posedge clk) begin
        if (clear) begin
            best_value <= '0;
            for (int i = 0; i < `WD_SLOTS; i++) begin
                best_guess[i] <= '0;
            end
        end else if (take) begin
            best_value <= score_value;
            best_guess <= score_guess;
        end
    end

endmodule

/* hw/wd_ctrl.sv */
// search controller
// sequences load, combination and permutation passes, then emits the result beats
`include "wd_params.svh"

module wd_ctrl import wd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  logic     combo_hit,
    input  logic     combo_done,
    input  logic     perm_done,
    input  value_t   best_value,
    input  letter_t  best_guess [`WD_SLOTS],
    output logic     load_en,
    output key_idx_t beat,
    output logic     combo_start,
    output logic     combo_step,
    output logic     perm_start,
    output logic     perm_step,
    output logic     clear,
    output logic     out_valid,
    output letter_t  result,
    output value_t   out_value
);

    wd_state_e state;
    wd_state_e state_nxt;
    key_idx_t  cnt;
    key_idx_t  cnt_nxt;

    // ========================================================================
    // FSM
    // ========================================================================
    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt + key_idx_t'(1);
        case (state)
            IDLE: begin
                cnt_nxt = '0;
                if (in_valid) begin
                    state_nxt = LOAD;
                    cnt_nxt   = key_idx_t'(1);
                end
            end
            LOAD: begin
                if (cnt == key_idx_t'(`WD_KEYS - 1)) begin
                    state_nxt = COMBO;
                end
            end
            COMBO: begin
                cnt_nxt = '0;
                if (combo_hit) begin
                    state_nxt = PERM;
                end else if (combo_done) begin
                    state_nxt = EMIT;
                end
            end
            PERM: begin
                cnt_nxt = '0;
                if (perm_done) begin
                    state_nxt = DRAIN;
                end
            end
            // two cycles for the scorer and keeper to settle
            DRAIN: begin
                if (cnt == key_idx_t'(1)) begin
                    state_nxt = combo_done ? EMIT : COMBO;
                    cnt_nxt   = '0;
                end
            end
            EMIT: begin
                if (cnt == key_idx_t'(`WD_SLOTS - 1)) begin
                    state_nxt = IDLE;
                    cnt_nxt   = '0;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
        end
    end

    assign load_en     = (state == IDLE && in_valid) || state == LOAD;
    assign beat        = cnt;
    assign combo_start = (state == LOAD) && (cnt == key_idx_t'(`WD_KEYS - 1));
    assign clear       = combo_start;
    assign perm_start  = (state == COMBO) && combo_hit;
    assign perm_step   = (state == PERM);
    assign combo_step  = (state == COMBO && !combo_hit && !combo_done) ||
                         (state == DRAIN && cnt == key_idx_t'(1) && !combo_done);

    // ========================================================================
    // output beats
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            out_value <= '0;
        end else if (state == EMIT) begin
            out_valid <= 1'b1;
            result    <= best_guess[cnt];
            out_value <= best_value;
        end else begin
            out_valid <= 1'b0;
            result    <= '0;
            out_value <= '0;
        end
    end

    a_out_beats: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(out_valid) |-> out_valid [*`WD_SLOTS] ##1 !out_valid
    );

endmodule

/* hw/wd_top.sv */
// word-guess search engine, top level
// loads keys, answer, weights and target, then reports the best matching guess
`include "wd_params.svh"

module wd_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [`WD_LETTER_W-1:0] keyboard,
    input  logic [`WD_LETTER_W-1:0] answer,
    input  logic [`WD_WEIGHT_W-1:0] weight,
    input  logic [`WD_COUNT_W-1:0]  match_target,
    output logic                    out_valid,
    output logic [`WD_LETTER_W-1:0] result,
    output logic [`WD_VALUE_W-1:0]  out_value
);

    // control
    logic                   load_en;
    logic [2:0]             beat;
    logic                   combo_start;
    logic                   combo_step;
    logic                   combo_hit;
    logic                   combo_done;
    logic                   perm_start;
    logic                   perm_step;
    logic                   perm_done;
    logic                   clear;
    logic                   guess_valid;
    logic                   score_valid;
    logic                   score_match;

    // loaded case data
    logic [`WD_LETTER_W-1:0] keys        [`WD_KEYS];
    logic [`WD_LETTER_W-1:0] answers     [`WD_SLOTS];
    logic [`WD_WEIGHT_W-1:0] weights     [`WD_SLOTS];
    logic [`WD_COUNT_W-1:0]  target_a;
    logic [`WD_COUNT_W-1:0]  target_b;

    // search datapath
    logic [`WD_LETTER_W-1:0] chosen      [`WD_SLOTS];
    logic [`WD_LETTER_W-1:0] guess       [`WD_SLOTS];
    logic [`WD_LETTER_W-1:0] score_guess [`WD_SLOTS];
    logic [`WD_LETTER_W-1:0] best_guess  [`WD_SLOTS];
    logic [`WD_VALUE_W-1:0]  score_value;
    logic [`WD_VALUE_W-1:0]  best_value;

    wd_input_buffer u_input_buffer (
        .clk, .rst_n, .load_en, .beat, .keyboard, .answer, .weight, .match_target,
        .keys, .answers, .weights, .target_a, .target_b
    );

    wd_combo_gen u_combo_gen (
        .clk, .rst_n, .combo_start, .combo_step, .keys, .answers, .target_a, .target_b,
        .chosen, .combo_hit, .combo_done
    );

    wd_perm_gen u_perm_gen (
        .clk, .rst_n, .perm_start, .perm_step, .chosen, .guess, .guess_valid, .perm_done
    );

    wd_scorer u_scorer (
        .clk, .rst_n, .guess, .guess_valid, .answers, .weights, .target_a, .target_b,
        .score_valid, .score_match, .score_value, .score_guess
    );

    wd_best_keeper u_best_keeper (
        .clk, .rst_n, .clear, .score_valid, .score_match, .score_value, .score_guess,
        .best_value, .best_guess
    );

    wd_ctrl u_ctrl (
        .clk, .rst_n, .in_valid, .combo_hit, .combo_done, .perm_done, .best_value,
        .best_guess, .load_en, .beat, .combo_start, .combo_step, .perm_start,
        .perm_step, .clear, .out_valid, .result, .out_value
    );

endmodule

/* testbench/wd_tb.sv */
// testbench for the word-guess search engine
// random, tie and no-match cases checked against a brute-force reference
`include "wd_params.svh"

module wd_tb import wd_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CASES  = 12;
    localparam int MAX_CYCLES = NUM_CASES * (8 + 56 * 123 + 10) + 64;

    // five letters, slot 0 in the low bits
    typedef logic [`WD_SLOTS-1:0][`WD_LETTER_W-1:0] word_t;

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    letter_t keyboard;
    letter_t answer;
    weight_t weight;
    count_t  match_target;
    logic    out_valid;
    letter_t result;
    value_t  out_value;

    // current case and its expected result
    letter_t    keys  [`WD_KEYS];
    letter_t    ans   [`WD_SLOTS];
    weight_t    wts   [`WD_SLOTS];
    int         order [`WD_KEYS];
    count_t     tgt_a;
    count_t     tgt_b;
    word_t      exp_guess;
    value_t     exp_value;
    logic [2:0] out_beat;
    int         cycles = 0;
    int         bursts = 0;

    wd_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    // ========================================================================
    // reference scoring
    // ========================================================================
    function automatic int count_exact(input word_t g);
        int n;
        n = 0;
        for (int i = 0; i < `WD_SLOTS; i++) begin
            if (g[i] == ans[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // answer letters found in some other slot of the guess
    function automatic int count_moved(input word_t g);
        int n;
        n = 0;
        for (int i = 0; i < `WD_SLOTS; i++) begin
            for (int j = 0; j < `WD_SLOTS; j++) begin
                if (i != j && g[j] == ans[i]) begin
                    n++;
                end
            end
        end
        return n;
    endfunction

    function automatic int weighted(input word_t g);
        int v;
        v = 0;
        for (int i = 0; i < `WD_SLOTS; i++) begin
            v += int'(g[i]) * int'(wts[i]);
        end
        return v;
    endfunction

    function automatic bit lex_before(input word_t g, input word_t h);
        for (int i = 0; i < `WD_SLOTS; i++) begin
            if (g[i] != h[i]) begin
                return g[i] < h[i];
            end
        end
        return 1'b0;
    endfunction

    // every ordered choice of 5 distinct keys, as five base-8 digits
    task automatic find_best();
        word_t      g;
        logic [7:0] used;
        bit         ok;
        bit         found;
        int         k;
        int         v;
        found     = 1'b0;
        exp_guess = '0;
        exp_value = '0;
        for (int n = 0; n < 32768; n++) begin
            used = '0;
            ok   = 1'b1;
            for (int s = 0; s < `WD_SLOTS; s++) begin
                k = (n >> (3 * s)) & 7;
                if (used[k]) begin
                    ok = 1'b0;
                end
                used[k] = 1'b1;
                g[s]    = keys[k];
            end
            if (ok && count_exact(g) == tgt_a && count_moved(g) == tgt_b) begin
                v = weighted(g);
                if (!found || v > exp_value || (v == exp_value && lex_before(g, exp_guess))) begin
                    found     = 1'b1;
                    exp_guess = g;
                    exp_value = value_t'(v);
                end
            end
        end
    endtask

    // ========================================================================
    // case setup and driving
    // ========================================================================
    task automatic shuffle_order();
        int j;
        int t;
        for (int i = 0; i < `WD_KEYS; i++) begin
            order[i] = i;
        end
        for (int i = `WD_KEYS - 1; i > 0; i--) begin
            j        = $urandom_range(i, 0);
            t        = order[i];
            order[i] = order[j];
            order[j] = t;
        end
    endtask

    // distinct letters 1..26 keep pair counts at 5 or less and values in 11 bits
    task automatic make_random_case();
        word_t g;
        bit    dup;
        for (int i = 0; i < `WD_KEYS; i++) begin
            do begin
                keys[i] = letter_t'($urandom_range(26, 1));
                dup     = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (keys[j] == keys[i]) begin
                        dup = 1'b1;
                    end
                end
            end while (dup);
        end
        shuffle_order();
        for (int s = 0; s < `WD_SLOTS; s++) begin
            ans[s] = keys[order[s]];
            wts[s] = weight_t'($urandom_range(15, 0));
        end
        // target taken from another random guess
        shuffle_order();
        for (int s = 0; s < `WD_SLOTS; s++) begin
            g[s] = keys[order[s]];
        end
        tgt_a = count_t'(count_exact(g));
        tgt_b = count_t'(count_moved(g));
    endtask

    // duplicate keys, equal weights, many top-valued guesses
    task automatic make_tie_case();
        word_t g;
        keys = '{5'd3, 5'd3, 5'd7, 5'd7, 5'd9, 5'd9, 5'd12, 5'd14};
        ans  = '{5'd3, 5'd7, 5'd9, 5'd12, 5'd14};
        wts  = '{4'd6, 4'd6, 4'd6, 4'd6, 4'd6};
        g[0] = 5'd7;
        g[1] = 5'd3;
        g[2] = 5'd12;
        g[3] = 5'd14;
        g[4] = 5'd9;
        tgt_a = count_t'(count_exact(g));
        tgt_b = count_t'(count_moved(g));
    endtask

    task automatic idle_inputs();
        in_valid     = 1'b0;
        keyboard     = '0;
        answer       = '0;
        weight       = '0;
        match_target = '0;
    endtask

    // beats past each field's count carry junk
    task automatic run_case(input bit poke);
        find_best();
        for (int b = 0; b < `WD_KEYS; b++) begin
            @(negedge clk);
            in_valid     = 1'b1;
            keyboard     = keys[b];
            answer       = (b < `WD_SLOTS) ? ans[b] : letter_t'($urandom);
            weight       = (b < `WD_SLOTS) ? wts[b] : weight_t'($urandom);
            match_target = (b == 0) ? tgt_a : (b == 1) ? tgt_b : count_t'($urandom);
        end
        @(negedge clk);
        idle_inputs();
        if (poke) begin
            // stray in_valid while the search runs
            repeat (10) @(negedge clk);
            in_valid = 1'b1;
            keyboard = letter_t'($urandom);
            repeat (2) @(negedge clk);
            idle_inputs();
        end
        while (!out_valid) @(negedge clk);
        while (out_valid) @(negedge clk);
    endtask

    // ========================================================================
    // output tracking and checks
    // ========================================================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_beat <= '0;
        end else begin
            if (out_valid && out_beat == 3'd0) begin
                bursts <= bursts + 1;
            end
            out_beat <= out_valid ? out_beat + 3'd1 : 3'd0;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            fail_run($sformatf("timeout: no result after %0d cycles", cycles));
        end
    end

    a_idle_result: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> result == '0)
        else fail_run($sformatf("mismatch result: got 0x%0h expected 0x0", $sampled(result)));

    a_idle_value: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out_value == '0)
        else fail_run($sformatf("mismatch out_value: got 0x%0h expected 0x0",
                                $sampled(out_value)));

    a_five_beats: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid) |-> out_valid [*`WD_SLOTS] ##1 !out_valid)
        else fail_run("out_valid did not stay high for exactly five cycles");

    a_value_steady: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && $past(out_valid) |-> $stable(out_value))
        else fail_run($sformatf("mismatch out_value: changed from 0x%0h to 0x%0h",
                                $past(out_value), $sampled(out_value)));

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> result == exp_guess[out_beat])
        else fail_run($sformatf("mismatch result: got 0x%0h expected 0x%0h",
                                $sampled(result), exp_guess[$sampled(out_beat)]));

    a_value: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_value == exp_value)
        else fail_run($sformatf("mismatch out_value: got 0x%0h expected 0x%0h",
                                $sampled(out_value), exp_value));

    initial begin
        void'($urandom(32'h9e296e73));
        rst_n = 1'b0;
        idle_inputs();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        for (int c = 0; c < 10; c++) begin
            make_random_case();
            run_case(c % 2 == 1);
        end
        make_tie_case();
        run_case(1'b0);
        // four in place and one moved has no distinct-key solution
        make_random_case();
        tgt_a = 3'd4;
        tgt_b = 3'd1;
        run_case(1'b1);
        repeat (4) @(negedge clk);
        if (bursts != NUM_CASES) begin
            fail_run($sformatf("expected %0d result bursts but saw %0d", NUM_CASES, bursts));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* tb.f */
+incdir+include
hw/wd_pkg.sv
hw/wd_input_buffer.sv
hw/wd_combo_gen.sv
hw/wd_perm_gen.sv
hw/wd_scorer.sv
hw/wd_best_keeper.sv
hw/wd_ctrl.sv
hw/wd_top.sv
testbench/wd_tb.sv
